// File: hw/nameTableBus.sv
`timescale 1ns/1ns
`default_nettype none

module nameTableBus #(
  parameter int NT_ADDR_WIDTH = 9
) (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  input  wire                      HSEL,
  input  wire ppuPkg::ahbAddrT     HADDR,
  input  wire [1:0]                HTRANS,
  input  wire [2:0]                HSIZE,
  input  wire                      HWRITE,
  input  wire ppuPkg::ahbDataT     HWDATA,
  input  wire                      HREADY,
  output logic                     HREADYOUT,
  output ppuPkg::ahbDataT          HRDATA,
  output logic [1:0]               HRESP,
  output logic [NT_ADDR_WIDTH-1:0] ramRdAddr,
  output logic [NT_ADDR_WIDTH-1:0] ramWrAddr,
  output ppuPkg::byteLaneT         ramWrLanes,
  output ppuPkg::ahbDataT          ramWrData,
  input  wire ppuPkg::ahbDataT     ramRdData,
  output ppuPkg::scrollCfgT        scrollCfg,
  input  wire ppuPkg::scrollStatT  scrollStat
);

  logic                   accept;
  ppuPkg::byteLaneT       laneDec;
  logic [NT_ADDR_WIDTH:0] wordIdx;   // top bit selects the register bank
  ppuPkg::byteLaneT       lanesReg;
  logic                   wrPending;
  logic                   dataWr;
  logic                   bankSel;
  logic                   regWr;
  ppuPkg::scrollCfgT      cfgReg;

  // zero wait states, never an error
  assign HREADYOUT = 1'b1;
  assign HRESP     = ppuPkg::HRESP_OKAY;

  assign accept = HSEL & HTRANS[1] & HREADY;

  // byte lanes from size and low address bits
  always_comb begin
    case ({HADDR[1:0], HSIZE})
      5'b00_000: laneDec = 4'b0001;
      5'b01_000: laneDec = 4'b0010;
      5'b10_000: laneDec = 4'b0100;
      5'b11_000: laneDec = 4'b1000;
      5'b00_001: laneDec = 4'b0011;
      5'b10_001: laneDec = 4'b1100;
      5'b00_010: laneDec = 4'b1111;
      default:   laneDec = 4'b0000; // unaligned or too wide
    endcase
  end

  // address phase capture
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wordIdx  <= '0;
      lanesReg <= '0;
    end else if (accept) begin
      wordIdx  <= HADDR[NT_ADDR_WIDTH+2:2];
      lanesReg <= laneDec;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wrPending <= 1'b0;
    end else begin
      wrPending <= accept & HWRITE;
    end
  end

  // data phase
  assign dataWr  = wrPending & HREADY;
  assign bankSel = wordIdx[NT_ADDR_WIDTH] && (wordIdx[NT_ADDR_WIDTH-1:3] == '0);
  assign regWr   = dataWr & bankSel;

  // RAM side; the read address bypasses the latch so data is ready next cycle
  assign ramRdAddr  = HADDR[NT_ADDR_WIDTH+1:2];
  assign ramWrAddr  = wordIdx[NT_ADDR_WIDTH-1:0];
  assign ramWrData  = HWDATA;
  assign ramWrLanes = (dataWr && !wordIdx[NT_ADDR_WIDTH]) ? lanesReg : '0;

  // scroll configuration registers
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      cfgReg <= '0;
    end else if (regWr) begin
      case (wordIdx[2:0])
        ppuPkg::SCROLL_EN[4:2]:   cfgReg.enable     <= HWDATA[0];
        ppuPkg::CNT_MAX[4:2]:     cfgReg.cntMax     <= HWDATA[7:0];
        ppuPkg::FLASH_START[4:2]: cfgReg.flashStart <= HWDATA[23:0];
        ppuPkg::BG_MAX[4:2]:      cfgReg.bgMax      <= HWDATA[7:0];
        ppuPkg::PAUSE[4:2]:       cfgReg.pause      <= HWDATA[0];
        default: ;                                  // status offsets
      endcase
    end
  end

  assign scrollCfg = cfgReg;

  // read data mux
  always_comb begin
    HRDATA = '0;
    if (!wordIdx[NT_ADDR_WIDTH]) begin
      HRDATA = ramRdData;
    end else if (bankSel) begin
      case (wordIdx[2:0])
        ppuPkg::SCROLL_EN[4:2]:   HRDATA = {31'b0, cfgReg.enable};
        ppuPkg::CNT_MAX[4:2]:     HRDATA = {24'b0, cfgReg.cntMax};
        ppuPkg::FLASH_START[4:2]: HRDATA = {8'b0, cfgReg.flashStart};
        ppuPkg::BG_MAX[4:2]:      HRDATA = {24'b0, cfgReg.bgMax};
        ppuPkg::BG_CNT[4:2]:      HRDATA = {24'b0, scrollStat.bgCnt};
        ppuPkg::SCROLL_PTR[4:2]:  HRDATA = {24'b0, scrollStat.scrollPtr};
        ppuPkg::SCROLLING[4:2]:   HRDATA = {31'b0, scrollStat.scrolling};
        ppuPkg::PAUSE[4:2]:       HRDATA = {31'b0, cfgReg.pause};
        default:                  HRDATA = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/nameTableRam.sv
`timescale 1ns/1ns
`default_nettype none

module nameTableRam #(
  parameter int NT_ADDR_WIDTH = 9
) (
  input  wire                         HCLK,
  input  wire [NT_ADDR_WIDTH-1:0]     rdAddr,
  input  wire [NT_ADDR_WIDTH-1:0]     wrAddr,
  input  wire ppuPkg::byteLaneT       wrLanes,
  input  wire ppuPkg::ahbDataT        wrData,
  input  wire [NT_ADDR_WIDTH-1:0]     renderAddr,
  output ppuPkg::ahbDataT             rdData,
  output ppuPkg::ahbDataT             renderData
);

  localparam int DEPTH = 2 ** NT_ADDR_WIDTH;

  ppuPkg::ahbDataT mem [DEPTH];

  // byte-lane write from the bus
  always_ff @(posedge HCLK) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (wrLanes[lane]) begin
        mem[wrAddr][8*lane +: 8] <= wrData[8*lane +: 8];
      end
    end
  end

  // bus read port, old data on a same-cycle write
  always_ff @(posedge HCLK) begin
    rdData <= mem[rdAddr];
  end

  // renderer read port
  always_ff @(posedge HCLK) begin
    renderData <= mem[renderAddr];
  end

endmodule

`default_nettype wire

// File: hw/ppuBackground.sv
`timescale 1ns/1ns
`default_nettype none

module ppuBackground #(
  parameter int NT_ADDR_WIDTH = 9
) (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  // AHB-Lite slave
  input  wire                      HSEL,
  input  wire ppuPkg::ahbAddrT     HADDR,
  input  wire [1:0]                HTRANS,
  input  wire [2:0]                HSIZE,
  input  wire                      HWRITE,
  input  wire ppuPkg::ahbDataT     HWDATA,
  input  wire                      HREADY,
  output logic                     HREADYOUT,
  output ppuPkg::ahbDataT          HRDATA,
  output logic [1:0]               HRESP,
  // renderer side
  input  wire [NT_ADDR_WIDTH-1:0]  renderAddr,
  output ppuPkg::ahbDataT          renderData,
  output ppuPkg::flashAddrT        flashAddrStart
);

  logic [NT_ADDR_WIDTH-1:0] ramRdAddr;
  logic [NT_ADDR_WIDTH-1:0] ramWrAddr;
  ppuPkg::byteLaneT         ramWrLanes;
  ppuPkg::ahbDataT          ramWrData;
  ppuPkg::ahbDataT          ramRdData;
  ppuPkg::scrollCfgT        scrollCfg;
  ppuPkg::scrollStatT       scrollStat;

  nameTableBus #(
    .NT_ADDR_WIDTH (NT_ADDR_WIDTH)
  ) uBus (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .HSEL       (HSEL),
    .HADDR      (HADDR),
    .HTRANS     (HTRANS),
    .HSIZE      (HSIZE),
    .HWRITE     (HWRITE),
    .HWDATA     (HWDATA),
    .HREADY     (HREADY),
    .HREADYOUT  (HREADYOUT),
    .HRDATA     (HRDATA),
    .HRESP      (HRESP),
    .ramRdAddr  (ramRdAddr),
    .ramWrAddr  (ramWrAddr),
    .ramWrLanes (ramWrLanes),
    .ramWrData  (ramWrData),
    .ramRdData  (ramRdData),
    .scrollCfg  (scrollCfg),
    .scrollStat (scrollStat)
  );

  nameTableRam #(
    .NT_ADDR_WIDTH (NT_ADDR_WIDTH)
  ) uRam (
    .HCLK       (HCLK),
    .rdAddr     (ramRdAddr),
    .wrAddr     (ramWrAddr),
    .wrLanes    (ramWrLanes),
    .wrData     (ramWrData),
    .renderAddr (renderAddr),
    .rdData     (ramRdData),
    .renderData (renderData)
  );

  scrollCtrl uScroll (
    .HCLK       (HCLK),
    .HRESETn    (HRESETn),
    .scrollCfg  (scrollCfg),
    .scrollStat (scrollStat)
  );

  // level data base for the flash fetcher outside this block
  assign flashAddrStart = scrollCfg.flashStart;

endmodule

`default_nettype wire

// File: hw/ppuPkg.sv
`default_nettype none

package ppuPkg;

  // bus widths
  typedef logic [31:0] ahbAddrT;
  typedef logic [31:0] ahbDataT;
  typedef logic [3:0]  byteLaneT;

  // scroll quantities
  typedef logic [7:0]  scrollCntT;
  typedef logic [23:0] flashAddrT;

  localparam logic [1:0] HRESP_OKAY = 2'b00;

  // scroll register byte offsets, one word apart above the name table
  localparam logic [11:0] SCROLL_EN   = 12'h800;
  localparam logic [11:0] CNT_MAX     = 12'h804;
  localparam logic [11:0] FLASH_START = 12'h808;
  localparam logic [11:0] BG_MAX      = 12'h80C;
  localparam logic [11:0] BG_CNT      = 12'h810; // read only
  localparam logic [11:0] SCROLL_PTR  = 12'h814; // read only
  localparam logic [11:0] SCROLLING   = 12'h818; // read only
  localparam logic [11:0] PAUSE       = 12'h81C;

  // bus slave to scroll engine, 42 bits
  typedef struct packed {
    logic      enable;
    logic      pause;
    scrollCntT cntMax;
    scrollCntT bgMax;
    flashAddrT flashStart;
  } scrollCfgT;

  // scroll engine back to bus slave, 17 bits
  typedef struct packed {
    scrollCntT bgCnt;
    scrollCntT scrollPtr;
    logic      scrolling;
  } scrollStatT;

endpackage

`default_nettype wire

// File: hw/scrollCtrl.sv
`timescale 1ns/1ns
`default_nettype none

module scrollCtrl (
  input  wire                      HCLK,
  input  wire                      HRESETn,
  input  wire ppuPkg::scrollCfgT   scrollCfg,
  output ppuPkg::scrollStatT       scrollStat
);

  typedef enum logic [1:0] {
    IDLE,
    SCROLLING,
    DONE
  } scrollStateT;

  scrollStateT       state;
  ppuPkg::scrollCntT prescale;
  ppuPkg::scrollCntT scrollPtr;
  ppuPkg::scrollCntT bgCnt;
  logic              enablePrev;
  logic              enableRise;
  logic              active;
  logic              step;
  logic              lastImage;

  assign enableRise = scrollCfg.enable & ~enablePrev;
  assign active     = scrollCfg.enable & ~scrollCfg.pause && (state == SCROLLING);
  // >= so a lowered limit still ends the count
  assign step       = active && (prescale >= scrollCfg.cntMax);
  assign lastImage  = (scrollPtr == 8'hFF) && (bgCnt == scrollCfg.bgMax);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      enablePrev <= 1'b0;
    end else begin
      enablePrev <= scrollCfg.enable;
    end
  end

  // prescaler holds while inactive
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      prescale <= '0;
    end else if (!enableRise && active) begin
      if (step) begin
        prescale <= '0;
      end else begin
        prescale <= prescale + 8'd1;
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= IDLE;
      scrollPtr <= '0;
      bgCnt     <= '0;
    end else if (enableRise) begin
      // restart from the first image
      state     <= SCROLLING;
      scrollPtr <= '0;
      bgCnt     <= '0;
    end else if (step) begin
      scrollPtr <= scrollPtr + 8'd1; // wraps 255 -> 0
      if (lastImage) begin
        state <= DONE;
      end else if (scrollPtr == 8'hFF) begin
        bgCnt <= bgCnt + 8'd1;
      end
    end
  end

  assign scrollStat.bgCnt     = bgCnt;
  assign scrollStat.scrollPtr = scrollPtr;
  assign scrollStat.scrolling = (state == SCROLLING);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the background PPU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary -Wno-fatal \
  --top-module ppuBackgroundTb \
  -f vlog.f \
  -o simv

./obj_dir/simv | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "run.sh: pass message found"
  exit 0
else
  echo "run.sh: pass message missing"
  exit 1
fi

// File: sim/ppuBackgroundCases.txt
# columns: name op addr(hex) size(dec) wdata(hex, r=random, -=none) expect(hex, m=model, -=none)
# ops: w write, r read, i idle, c wait (size column = cycles), n renderer read
w_word      w 010 2 11223344 -
i_word      i 000 0 - -
r_word      r 010 2 - 11223344
w_half_hi   w 012 1 aabb0000 -
w_byte1     w 011 0 0000cc00 -
w_half_odd  w 011 1 ffffffff -
w_word_odd  w 013 2 ffffffff -
i_merge     i 000 0 - -
r_merge     r 010 2 - aabbcc44
w_rand      w 1fc 2 r -
i_rand      i 000 0 - -
r_rand      r 1fc 2 - m
w_cnt_max   w 804 2 12345602 -
w_flash     w 808 2 ab123456 -
w_bg_max    w 80c 2 ffffff05 -
w_ro_ptr    w 814 2 00000055 -
i_regs      i 000 0 - -
r_cnt_max   r 804 2 - 00000002
r_flash     r 808 2 - 00123456
r_bg_max    r 80c 2 - 00000005
r_ro_ptr    r 814 2 - 00000000
r_unmapped  r 820 2 - 00000000
w_enable    w 800 2 00000001 -
c_run       c 000 20 - -
r_ptr_run   r 814 2 - m
r_enable    r 800 2 - 00000001
w_pause_on  w 81c 2 00000001 -
i_pause     i 000 0 - -
r_ptr_frz0  r 814 2 - m
c_frozen    c 000 12 - -
r_ptr_frz1  r 814 2 - m
w_pause_off w 81c 2 00000000 -
c_resume    c 000 12 - -
r_ptr_res   r 814 2 - m
w_disable   w 800 2 00000000 -
w_cnt_zero  w 804 2 00000000 -
w_bg_one    w 80c 2 00000001 -
w_restart   w 800 2 00000001 -
c_img0      c 000 100 - -
r_bg_img0   r 810 2 - m
c_img1      c 000 300 - -
r_bg_img1   r 810 2 - m
r_scr_on    r 818 2 - 00000001
c_done      c 000 300 - -
r_scr_off   r 818 2 - 00000000
r_bg_done   r 810 2 - m
n_word      n 010 0 - aabbcc44
n_rand      n 1fc 0 - m

// File: sim/ppuBackgroundChecker.sv
`timescale 1ns/1ns
`default_nettype none

module ppuBackgroundChecker #(
  parameter int NT_ADDR_WIDTH = 9
) (
  input wire                     HCLK,
  input wire                     HRESETn,
  input wire                     HSEL,
  input wire ppuPkg::ahbAddrT    HADDR,
  input wire [1:0]               HTRANS,
  input wire [2:0]               HSIZE,
  input wire                     HWRITE,
  input wire ppuPkg::ahbDataT    HWDATA,
  input wire                     HREADY,
  input wire                     HREADYOUT,
  input wire ppuPkg::ahbDataT    HRDATA,
  input wire [1:0]               HRESP,
  input wire [NT_ADDR_WIDTH-1:0] renderAddr,
  input wire ppuPkg::ahbDataT    renderData,
  input wire [23:0]              flashAddrStart
);

  logic [31:0] ram [2**NT_ADDR_WIDTH]; // shadow name table
  logic        cfgEnable, cfgPause;
  logic [7:0]  cfgCntMax, cfgBgMax;
  logic [23:0] cfgFlash;
  logic [7:0]  mPre, mPtr, mBg;        // scroll model
  logic        mScrolling, mPrevEn;

  string       rdNameQ[$];
  logic [31:0] rdExpQ[$];
  bit          rdModelQ[$];
  string       rnNameQ[$];
  logic [31:0] rnExpQ[$];
  bit          rnModelQ[$];

  logic        dpRead, dpWrite;
  logic [31:0] dpAddr, dpExp, dpRamVal;
  logic [3:0]  dpLanes;
  bit          dpModel;
  string       dpName;
  logic        rnArmed;
  logic [31:0] rnExp, rnVal;
  bit          rnModel;
  string       rnName;

  int errorCount = 0;
  int checkCount = 0;

  task automatic expectRead(input string name, input logic [31:0] exp, input bit model);
    rdNameQ.push_back(name);
    rdExpQ.push_back(exp);
    rdModelQ.push_back(model);
  endtask

  task automatic expectRender(input string name, input logic [31:0] exp, input bit model);
    rnNameQ.push_back(name);
    rnExpQ.push_back(exp);
    rnModelQ.push_back(model);
  endtask

  task automatic noteProblem(input string msg);
    errorCount++;
    $display("%s", msg);
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checkCount++;
    if (act !== exp) begin
      errorCount++;
      $display("Fail %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report();
    $display("checks %0d, errors %0d", checkCount, errorCount);
  endtask

  // aligned byte, halfword or word only
  function automatic logic [3:0] lanesFor(input logic [1:0] a, input logic [2:0] size);
    if (size == 3'd0) return 4'b0001 << a;
    if (size == 3'd1 && !a[0]) return a[1] ? 4'b1100 : 4'b0011;
    if (size == 3'd2 && a == 2'b00) return 4'b1111;
    return 4'b0000;
  endfunction

  // register bank sits right above the last name-table word
  function automatic bit inBank(input logic [31:0] a);
    return a[NT_ADDR_WIDTH+2] && (a[NT_ADDR_WIDTH+1:5] == '0);
  endfunction

  function automatic logic [31:0] regValue(input logic [2:0] idx);
    case (idx)
      3'd0: return {31'b0, cfgEnable};
      3'd1: return {24'b0, cfgCntMax};
      3'd2: return {8'b0, cfgFlash};
      3'd3: return {24'b0, cfgBgMax};
      3'd4: return {24'b0, mBg};
      3'd5: return {24'b0, mPtr};
      3'd6: return {31'b0, mScrolling};
      default: return {31'b0, cfgPause};
    endcase
  endfunction

  task automatic stepScroll();
    bit rise;
    bit act;
    rise = cfgEnable && !mPrevEn;
    act  = cfgEnable && !cfgPause && mScrolling;
    if (rise) begin
      mScrolling = 1'b1;
      mPtr       = 8'd0;
      mBg        = 8'd0;
    end else if (act) begin
      if (mPre >= cfgCntMax) begin
        mPre = 8'd0;
        if (mPtr == 8'hFF) begin
          if (mBg == cfgBgMax) mScrolling = 1'b0; // last image done
          else mBg = mBg + 8'd1;
        end
        mPtr = mPtr + 8'd1;
      end else begin
        mPre = mPre + 8'd1;
      end
    end
    mPrevEn = cfgEnable;
  endtask

  task automatic applyWrite();
    if (!dpAddr[NT_ADDR_WIDTH+2]) begin
      for (int b = 0; b < 4; b++) begin
        if (dpLanes[b]) ram[dpAddr[NT_ADDR_WIDTH+1:2]][8*b +: 8] = HWDATA[8*b +: 8];
      end
    end else if (inBank(dpAddr)) begin
      case (dpAddr[4:2])
        3'd0: cfgEnable = HWDATA[0];
        3'd1: cfgCntMax = HWDATA[7:0];
        3'd2: cfgFlash  = HWDATA[23:0];
        3'd3: cfgBgMax  = HWDATA[7:0];
        3'd7: cfgPause  = HWDATA[0];
        default: ;                                // status is read only
      endcase
    end
  endtask

  // sample mid-cycle, away from the driving edge
  always @(negedge HCLK) begin
    if (!HRESETn) begin
      {cfgEnable, cfgPause, cfgCntMax, cfgBgMax, cfgFlash} = '0;
      {mPre, mPtr, mBg, mScrolling, mPrevEn} = '0;
      dpRead  = 1'b0;
      dpWrite = 1'b0;
      rnArmed = 1'b0;
    end else begin
      if (HRESP !== 2'b00) noteProblem("bus returned a non-OKAY response");
      if (HREADYOUT !== 1'b1) noteProblem("HREADYOUT went low");
      if (flashAddrStart !== cfgFlash) noteProblem("flashAddrStart does not follow FLASH_START");

      if (dpRead) begin
        if (!dpModel) compare(dpName, dpExp, HRDATA);
        else if (!dpAddr[NT_ADDR_WIDTH+2]) compare(dpName, dpRamVal, HRDATA);
        else if (inBank(dpAddr)) compare(dpName, regValue(dpAddr[4:2]), HRDATA);
        else compare(dpName, 32'h0, HRDATA);
      end
      if (rnArmed) begin
        compare(rnName, rnModel ? rnVal : rnExp, renderData);
        rnArmed = 1'b0;
      end

      // snapshots taken before this cycle's write lands
      if (rnNameQ.size() > 0) begin
        rnName  = rnNameQ.pop_front();
        rnExp   = rnExpQ.pop_front();
        rnModel = rnModelQ.pop_front();
        rnVal   = ram[renderAddr];
        rnArmed = 1'b1;
      end
      dpRamVal = ram[HADDR[NT_ADDR_WIDTH+1:2]];

      stepScroll();
      if (dpWrite) applyWrite();

      // next address phase
      dpRead  = HSEL && HTRANS[1] && HREADY && !HWRITE;
      dpWrite = HSEL && HTRANS[1] && HREADY && HWRITE;
      dpAddr  = HADDR;
      dpLanes = lanesFor(HADDR[1:0], HSIZE);
      if (dpRead) begin
        if (rdNameQ.size() == 0) begin
          noteProblem("read transfer seen with no expected value queued");
          dpRead = 1'b0;
        end else begin
          dpName  = rdNameQ.pop_front();
          dpExp   = rdExpQ.pop_front();
          dpModel = rdModelQ.pop_front();
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/ppuBackgroundTb.sv
`timescale 1ns/1ns
`default_nettype none

module ppuBackgroundTb;

  localparam int NT_ADDR_WIDTH = 9;

  logic                     HCLK;
  logic                     HRESETn;
  logic                     HSEL;
  ppuPkg::ahbAddrT          HADDR;
  logic [1:0]               HTRANS;
  logic [2:0]               HSIZE;
  logic                     HWRITE;
  ppuPkg::ahbDataT          HWDATA;
  logic                     HREADY;
  logic                     HREADYOUT;
  ppuPkg::ahbDataT          HRDATA;
  logic [1:0]               HRESP;
  logic [NT_ADDR_WIDTH-1:0] renderAddr;
  ppuPkg::ahbDataT          renderData;
  logic [23:0]              flashAddrStart;

  string       cName[$];
  string       cOp[$];
  logic [31:0] cAddr[$];
  int          cSize[$];
  logic [31:0] cData[$];
  string       cExp[$];
  int          maxWait = 0;
  bit          loaded = 0;
  logic [31:0] wrDataHold = '0; // HWDATA for the next data phase

  ppuBackground #(.NT_ADDR_WIDTH(NT_ADDR_WIDTH)) dut (.*);

  ppuBackgroundChecker #(.NT_ADDR_WIDTH(NT_ADDR_WIDTH)) chk (.*);

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  task automatic loadCases();
    int fd;
    int n;
    string line, name, op, wStr, eStr;
    logic [31:0] addr, data;
    int size;
    fd = $fopen("sim/ppuBackgroundCases.txt", "r");
    if (fd == 0) begin
      chk.noteProblem("could not open the case file");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%s %s %h %d %s %s", name, op, addr, size, wStr, eStr);
      if (n != 6) begin
        chk.noteProblem({"malformed case line: ", line});
        continue;
      end
      data = '0;
      if (wStr == "r") data = $urandom;
      else if (wStr != "-") n = $sscanf(wStr, "%h", data);
      if (op == "c" && size > maxWait) maxWait = size;
      cName.push_back(name);
      cOp.push_back(op);
      cAddr.push_back(addr);
      cSize.push_back(size);
      cData.push_back(data);
      cExp.push_back(eStr);
    end
    $fclose(fd);
  endtask

  // one address phase; also moves the previous write data into its data phase
  task automatic addrPhase(input logic [31:0] a, input logic [2:0] s, input logic w,
                           input logic [31:0] d, input logic act);
    @(posedge HCLK);
    HWDATA <= wrDataHold;
    HSEL   <= act;
    HTRANS <= act ? 2'b10 : 2'b00;
    HADDR  <= a;
    HSIZE  <= s;
    HWRITE <= w;
    wrDataHold = d;
  endtask

  task automatic idle();
    addrPhase(32'h0, 3'd0, 1'b0, 32'h0, 1'b0);
  endtask

  task automatic runCase(input int i);
    logic [31:0] exp;
    bit model;
    int n;
    exp   = '0;
    model = (cExp[i] == "m");
    if (!model && cExp[i] != "-") n = $sscanf(cExp[i], "%h", exp);
    repeat ($urandom_range(0, 2)) idle();
    case (cOp[i])
      "w": addrPhase(cAddr[i], 3'(cSize[i]), 1'b1, cData[i], 1'b1);
      "r": begin
        addrPhase(cAddr[i], 3'(cSize[i]), 1'b0, 32'h0, 1'b1);
        chk.expectRead(cName[i], exp, model);
      end
      "i": idle();
      "c": repeat (cSize[i]) idle();
      "n": begin
        idle();
        renderAddr <= cAddr[i][NT_ADDR_WIDTH+1:2];
        chk.expectRender(cName[i], exp, model);
        idle(); // result shows one cycle later
        renderAddr <= ~cAddr[i][NT_ADDR_WIDTH+1:2]; // step away so an early word differs
      end
      default: chk.noteProblem({"unknown operation in case ", cName[i]});
    endcase
  endtask

  initial begin
    void'($urandom(88));
    HRESETn    = 1'b0;
    HSEL       = 1'b0;
    HADDR      = '0;
    HTRANS     = 2'b00;
    HSIZE      = 3'd0;
    HWRITE     = 1'b0;
    HWDATA     = '0;
    HREADY     = 1'b1;
    renderAddr = '0;
    loadCases();
    loaded = 1'b1;
    repeat (3) @(posedge HCLK);
    HRESETn <= 1'b1;
    for (int i = 0; i < cName.size(); i++) begin
      runCase(i);
    end
    repeat (4) idle();
    chk.report();
    if (chk.errorCount == 0 && cName.size() > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // watchdog sized from the case list
  initial begin
    wait (loaded);
    repeat (cName.size() * (maxWait + 4) + 10) @(posedge HCLK);
    $display("timeout: the case list did not complete in the allowed cycles");
    chk.report();
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
hw/ppuPkg.sv
hw/nameTableBus.sv
hw/nameTableRam.sv
hw/scrollCtrl.sv
hw/ppuBackground.sv
sim/ppuBackgroundChecker.sv
sim/ppuBackgroundTb.sv
